// ==== filelist.f ====
+incdir+.
io_pkg.sv
dma_pkg.sv
hub_if.sv
sync_fifo.sv
io_regs.sv
dma_master.sv
io_hub.sv
io_hub_props.sv
io_hub_tb.sv

// ==== Bender.yml ====
package:
  name: io_hub

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - io_pkg.sv
      - dma_pkg.sv
      - hub_if.sv
      - sync_fifo.sv
      - io_regs.sv
      - dma_master.sv
      - io_hub.sv
  - target: test
    include_dirs:
      - .
    files:
      - io_hub_props.sv
      - io_hub_tb.sv

// ==== io_hub_tb.sv ====
`timescale 1ns/1ps
`include "hub_consts.svh"

module io_hub_tb;

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_CAPTURE, OP_DMA} op_e;

	// addr and data are the register access, or first address and pause point for a DMA run
	typedef struct packed {
		op_e                    op;
		logic [`HUB_ADDR_W-1:0] addr;
		io_pkg::reg_word_t      data;
		logic [7:0]             count;
	} step_t;

	logic                   clk;
	logic                   rst;
	logic [`HUB_DATA_W-1:0] data_i;
	logic                   data_valid_i;
	logic                   io_stb_i;
	logic                   io_we_i;
	logic [`HUB_ADDR_W-1:0] io_addr_i;
	logic [`HUB_DATA_W-1:0] io_wdata_i;
	logic                   io_ack_o;
	logic [`HUB_DATA_W-1:0] io_data_o;
	logic                   mem_cyc_i;
	logic                   mem_stb_o;
	logic                   mem_we_o;
	logic [`HUB_ADDR_W-1:0] mem_addr_o;
	logic [`HUB_DATA_W-1:0] mem_data_o;
	logic                   mem_ack_i;

	logic [31:0]        lcg_state = 32'd70;
	logic               capture_on = 1'b0;
	int                 err_count = 0;
	int                 cycles = 0;
	int                 cycle_limit = 0;
	int                 mem_writes = 0;
	dma_pkg::mem_word_t exp_fifo [$];      // Expected FIFO contents
	dma_pkg::mem_addr_t addr_log [$];      // Addresses in completion order
	dma_pkg::mem_word_t mem_model [dma_pkg::mem_addr_t];

	step_t steps [27] = '{
		'{OP_READ,    io_pkg::REG_STATUS,     32'h0000_0400, 8'd0},
		'{OP_READ,    16'h0009,               32'h0000_0000, 8'd0}, // Unmapped
		'{OP_WRITE,   io_pkg::REG_ADDR_FIRST, 32'h0000_0100, 8'd0},
		'{OP_READ,    io_pkg::REG_ADDR_FIRST, 32'h0000_0100, 8'd0},
		'{OP_WRITE,   io_pkg::REG_ADDR_END,   32'h0000_0104, 8'd0},
		'{OP_READ,    io_pkg::REG_ADDR_END,   32'h0000_0104, 8'd0},
		'{OP_WRITE,   io_pkg::REG_STATUS,     32'h0000_0700, 8'd0}, // Read-only bits only
		'{OP_READ,    io_pkg::REG_STATUS,     32'h0000_0400, 8'd0},
		'{OP_CAPTURE, 16'h0000,               32'h0000_0000, 8'd3}, // Capture still off
		'{OP_READ,    io_pkg::REG_LEVEL,      32'h0000_0000, 8'd0},
		'{OP_WRITE,   io_pkg::REG_STATUS,     32'h0000_0004, 8'd0},
		'{OP_READ,    io_pkg::REG_STATUS,     32'h0000_0404, 8'd0},
		'{OP_CAPTURE, 16'h0000,               32'h0000_0000, 8'd5},
		'{OP_READ,    io_pkg::REG_LEVEL,      32'h0000_0005, 8'd0},
		'{OP_CAPTURE, 16'h0000,               32'h0000_0000, 8'd6}, // Three beyond depth
		'{OP_READ,    io_pkg::REG_LEVEL,      32'h0000_0008, 8'd0},
		'{OP_READ,    io_pkg::REG_STATUS,     32'h0000_0204, 8'd0},
		'{OP_READ,    io_pkg::REG_DROPS,      32'h0000_0003, 8'd0},
		'{OP_DMA,     16'h0100,               32'h0000_0000, 8'd5},
		'{OP_READ,    io_pkg::REG_STATUS,     32'h0000_0101, 8'd0},
		'{OP_READ,    io_pkg::REG_LEVEL,      32'h0000_0003, 8'd0}, // Left behind the window
		'{OP_WRITE,   io_pkg::REG_STATUS,     32'h0000_0004, 8'd0},
		'{OP_CAPTURE, 16'h0000,               32'h0000_0000, 8'd3},
		'{OP_READ,    io_pkg::REG_LEVEL,      32'h0000_0006, 8'd0},
		'{OP_DMA,     16'h0200,               32'h0000_0002, 8'd6}, // Grant pause after 2
		'{OP_READ,    io_pkg::REG_STATUS,     32'h0000_0501, 8'd0},
		'{OP_READ,    io_pkg::REG_DROPS,      32'h0000_0003, 8'd0}
	};

	io_hub dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int step_cycles(input step_t s);
		case (s.op)
			OP_CAPTURE: return s.count + 4;
			OP_DMA:     return 8 * s.count + 80;
			default:    return 8;
		endcase
	endfunction

	// ##########################################################################
	// Checks

	task automatic report_error(input string msg);
		err_count++;
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input io_pkg::reg_word_t got,
			input io_pkg::reg_word_t exp);
		if (got !== exp)
			report_error($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input dma_pkg::mem_addr_t got,
			input dma_pkg::mem_addr_t exp);
		if (got !== exp)
			report_error($sformatf("Fail %s: got 0x%04h, expected 0x%04h", name, got, exp));
	endtask

	task automatic check_mem(input string name, input dma_pkg::mem_word_t got,
			input dma_pkg::mem_word_t exp);
		if (got !== exp)
			report_error($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp));
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("Finished with errors");
			$fatal(1, "Timeout");
		end
	end

	// ##########################################################################
	// Bus drivers and memory model

	task automatic bus_access(input logic we, input logic [`HUB_ADDR_W-1:0] addr,
			input io_pkg::reg_word_t wdata, output io_pkg::reg_word_t rdata);
		int waits;
		@(posedge clk);
		io_stb_i   <= 1'b1;
		io_we_i    <= we;
		io_addr_i  <= addr;
		io_wdata_i <= wdata;
		waits = 0;
		do begin
			@(negedge clk);
			waits++;
		end while (!io_ack_o);
		// Ack is due exactly one cycle after the strobe
		if (waits != 2)
			report_error($sformatf("io_ack_o came %0d cycles after io_stb_i instead of one",
				waits - 1));
		rdata = io_data_o;
		@(posedge clk);
		io_stb_i <= 1'b0;
		io_we_i  <= 1'b0;
		do @(negedge clk); while (io_ack_o);
	endtask

	task automatic capture_words(input int n);
		dma_pkg::mem_word_t w;
		for (int i = 0; i < n; i++) begin
			w = lcg_next();
			@(posedge clk);
			data_i       <= w;
			data_valid_i <= 1'b1;
			if (capture_on && exp_fifo.size() < `HUB_FIFO_DEPTH)
				exp_fifo.push_back(w);
		end
		@(posedge clk);
		data_valid_i <= 1'b0;
	endtask

	// Ack after 0 to 3 stall cycles, one word per ack
	initial begin : memory_model
		int   stall;
		logic ack_next;
		stall     = -1;
		mem_ack_i = 1'b0;
		forever begin
			@(negedge clk);
			ack_next = 1'b0;
			if (mem_stb_o && mem_ack_i) begin
				if (mem_we_o !== 1'b1)
					report_error($sformatf("Fail mem_we_o: got 0x%0h, expected 0x1", mem_we_o));
				mem_model[mem_addr_o] = mem_data_o;
				addr_log.push_back(mem_addr_o);
				mem_writes++;
				stall = -1;
			end else if (mem_stb_o) begin
				if (stall < 0)
					stall = int'((lcg_next() >> 16) & 32'd3);
				if (stall == 0)
					ack_next = 1'b1;
				else
					stall--;
			end
			@(posedge clk);
			mem_ack_i <= ack_next;
		end
	end

	task automatic run_dma(input dma_pkg::mem_addr_t first, input int pause_at, input int n);
		io_pkg::reg_word_t  rd;
		io_pkg::status_t    st;
		dma_pkg::mem_addr_t a;
		int                 base;
		int                 held;
		base = mem_writes;
		bus_access(1'b1, io_pkg::REG_ADDR_FIRST, io_pkg::reg_word_t'(first), rd);
		bus_access(1'b1, io_pkg::REG_ADDR_END, io_pkg::reg_word_t'(first + n - 1), rd);
		bus_access(1'b1, io_pkg::REG_STATUS, 32'h0, rd);
		capture_on = 1'b0;
		bus_access(1'b1, io_pkg::REG_STATUS, 32'h1, rd); // run 0 to 1 starts the DMA
		if (pause_at > 0) begin
			do @(negedge clk); while (mem_writes - base < pause_at);
			@(posedge clk);
			mem_cyc_i <= 1'b0;
			held = mem_writes;
			repeat (20) @(negedge clk);
			check_word("memory writes while mem_cyc_i low", mem_writes, held);
			@(posedge clk);
			mem_cyc_i <= 1'b1;
		end
		do begin
			bus_access(1'b0, io_pkg::REG_STATUS, 32'h0, rd);
			st = io_pkg::status_t'(rd);
		end while (!st.done);
		repeat (10) @(negedge clk);
		check_word("memory write count", mem_writes - base, n);
		for (int i = 0; i < n; i++) begin
			a = first + i;
			check_addr("mem_addr_o", addr_log[base + i], a);
			if (!mem_model.exists(a))
				report_error($sformatf("No memory write reached address 0x%04h", a));
			check_mem("mem_data_o", mem_model[a], exp_fifo.pop_front());
		end
	endtask

	// ##########################################################################
	// Stimulus

	initial begin
		io_pkg::reg_word_t rd;
		io_pkg::status_t   st;
		int                total;
		rst          = 1'b1;
		data_i       = '0;
		data_valid_i = 1'b0;
		io_stb_i     = 1'b0;
		io_we_i      = 1'b0;
		io_addr_i    = '0;
		io_wdata_i   = '0;
		mem_cyc_i    = 1'b1;
		total        = 10;
		foreach (steps[i])
			total += step_cycles(steps[i]);
		cycle_limit = 10 * total;

		repeat (10) @(posedge clk);
		rst <= 1'b0;

		foreach (steps[i]) begin
			case (steps[i].op)
				OP_WRITE: begin
					bus_access(1'b1, steps[i].addr, steps[i].data, rd);
					if (steps[i].addr == io_pkg::REG_STATUS) begin
						st         = io_pkg::status_t'(steps[i].data);
						capture_on = st.capture;
					end
				end
				OP_READ: begin
					bus_access(1'b0, steps[i].addr, 32'h0, rd);
					check_word("io_data_o", rd, steps[i].data);
				end
				OP_CAPTURE: capture_words(steps[i].count);
				OP_DMA:     run_dma(steps[i].addr, int'(steps[i].data), steps[i].count);
				default:    report_error("Unknown operation in the stimulus table");
			endcase
		end

		if (err_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== io_hub_props.sv ====
`timescale 1ns/1ps
`include "hub_consts.svh"

module io_hub_props (
	input logic                   clk,
	input logic                   rst,
	input logic                   io_stb_i,
	input logic                   io_ack_o,
	input logic                   mem_stb_o,
	input logic                   mem_ack_i,
	input logic [`HUB_ADDR_W-1:0] mem_addr_o,
	input logic [`HUB_DATA_W-1:0] mem_data_o,
	input logic                   fifo_full,
	input logic                   fifo_empty
);

	// Ack only answers a strobe seen the cycle before
	ack_needs_stb: assert property (@(posedge clk) disable iff (rst)
		$rose(io_ack_o) |-> $past(io_stb_i))
		else $error("io_ack_o rose without io_stb_i");

	// Stalled word and address stay put
	mem_hold: assert property (@(posedge clk) disable iff (rst)
		mem_stb_o && !mem_ack_i |=> $stable(mem_addr_o) && $stable(mem_data_o))
		else $error("mem_addr_o or mem_data_o changed before mem_ack_i");

	fifo_flags: assert property (@(posedge clk) disable iff (rst)
		!(fifo_full && fifo_empty))
		else $error("FIFO full and empty at the same time");

endmodule

bind io_hub io_hub_props props0 (.*);

// ==== io_hub.sv ====
`timescale 1ns/1ps
`include "hub_consts.svh"

module io_hub (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`HUB_DATA_W-1:0] data_i,
	input  logic                   data_valid_i,
	input  logic                   io_stb_i,
	input  logic                   io_we_i,
	input  logic [`HUB_ADDR_W-1:0] io_addr_i,
	input  logic [`HUB_DATA_W-1:0] io_wdata_i,
	output logic                   io_ack_o,
	output logic [`HUB_DATA_W-1:0] io_data_o,
	input  logic                   mem_cyc_i,
	output logic                   mem_stb_o,
	output logic                   mem_we_o,
	output logic [`HUB_ADDR_W-1:0] mem_addr_o,
	output logic [`HUB_DATA_W-1:0] mem_data_o,
	input  logic                   mem_ack_i
);
	io_bus_if  io_bus ();
	mem_bus_if mem_bus ();

	logic                    fifo_push;
	logic                    fifo_pop;
	logic                    fifo_full;
	logic                    fifo_empty;
	logic [`HUB_LEVEL_W-1:0] fifo_level;
	dma_pkg::mem_word_t      fifo_dout;
	logic                    run;
	logic                    start;
	logic                    capture;
	logic                    dma_done;
	dma_pkg::mem_addr_t      addr_first;
	dma_pkg::mem_addr_t      addr_end;

	// ##########################################################################
	// Plain ports onto the internal buses

	assign io_bus.stb   = io_stb_i;
	assign io_bus.we    = io_we_i;
	assign io_bus.addr  = io_addr_i;
	assign io_bus.wdata = io_wdata_i;
	assign io_ack_o     = io_bus.ack;
	assign io_data_o    = io_bus.rdata;

	assign mem_bus.cyc  = mem_cyc_i;
	assign mem_bus.ack  = mem_ack_i;
	assign mem_stb_o    = mem_bus.stb;
	assign mem_we_o     = mem_bus.we;
	assign mem_addr_o   = mem_bus.addr;
	assign mem_data_o   = mem_bus.data;

	// Capture only while enabled, a full FIFO drops the word
	assign fifo_push = data_valid_i && capture && !fifo_full;

	sync_fifo #(
		.DEPTH(`HUB_FIFO_DEPTH)
	) fifo0 (
		.clk     (clk),
		.rst     (rst),
		.push_i  (fifo_push),
		.din_i   (data_i),
		.pop_i   (fifo_pop),
		.dout_o  (fifo_dout),
		.full_o  (fifo_full),
		.empty_o (fifo_empty),
		.level_o (fifo_level)
	);

	io_regs regs0 (
		.clk          (clk),
		.rst          (rst),
		.bus          (io_bus.slave),
		.data_valid_i (data_valid_i),
		.fifo_full_i  (fifo_full),
		.fifo_empty_i (fifo_empty),
		.fifo_level_i (fifo_level),
		.dma_done_i   (dma_done),
		.run_o        (run),
		.start_o      (start),
		.capture_o    (capture),
		.addr_first_o (addr_first),
		.addr_end_o   (addr_end)
	);

	dma_master dma0 (
		.clk          (clk),
		.rst          (rst),
		.mem          (mem_bus.master),
		.start_i      (start),
		.run_i        (run),
		.addr_first_i (addr_first),
		.addr_end_i   (addr_end),
		.fifo_empty_i (fifo_empty),
		.fifo_dout_i  (fifo_dout),
		.fifo_pop_o   (fifo_pop),
		.done_o       (dma_done)
	);

endmodule

// ==== dma_master.sv ====
`timescale 1ns/1ps

module dma_master (
	input  logic               clk,
	input  logic               rst,
	mem_bus_if.master          mem,
	input  logic               start_i,
	input  logic               run_i,
	input  dma_pkg::mem_addr_t addr_first_i,
	input  dma_pkg::mem_addr_t addr_end_i,
	input  logic               fifo_empty_i,
	input  dma_pkg::mem_word_t fifo_dout_i,
	output logic               fifo_pop_o,
	output logic               done_o
);
	dma_pkg::dma_state_e state;
	dma_pkg::mem_addr_t  count;     // Words written since start
	dma_pkg::mem_addr_t  cur_addr;
	logic                beat_done;
	logic                last_word;

	// ##########################################################################
	// Bus side

	assign cur_addr  = addr_first_i + count;
	assign last_word = (cur_addr == addr_end_i);

	// Strobe drops with the grant or an empty FIFO, count is kept
	assign mem.stb   = (state == dma_pkg::DMA_WRITE) && mem.cyc && !fifo_empty_i;
	assign mem.we    = mem.stb;
	assign mem.addr  = cur_addr;
	assign mem.data  = fifo_dout_i; // Head stays put until the pop

	assign beat_done  = mem.stb && mem.ack;
	assign fifo_pop_o = beat_done;

	// ##########################################################################
	// FSM

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= dma_pkg::DMA_IDLE;
			count  <= '0;
			done_o <= 1'b0;
		end else begin
			case (state)
				dma_pkg::DMA_IDLE: begin
					if (start_i) begin
						state  <= dma_pkg::DMA_WRITE;
						count  <= '0;
						done_o <= 1'b0;
					end
				end
				dma_pkg::DMA_WRITE: begin
					if (beat_done) begin
						count <= count + 1'b1;
						if (last_word) begin
							state  <= dma_pkg::DMA_DONE;
							done_o <= 1'b1;
						end
					end
					// Clearing run aborts, a word completing now is still counted
					if (!run_i)
						state <= dma_pkg::DMA_IDLE;
				end
				dma_pkg::DMA_DONE: begin
					if (!run_i)
						state <= dma_pkg::DMA_IDLE; // done stays until next start
				end
				default: state <= dma_pkg::DMA_IDLE;
			endcase
		end
	end

endmodule

// ==== io_regs.sv ====
`timescale 1ns/1ps
`include "hub_consts.svh"

module io_regs (
	input  logic                    clk,
	input  logic                    rst,
	io_bus_if.slave                 bus,
	input  logic                    data_valid_i,
	input  logic                    fifo_full_i,
	input  logic                    fifo_empty_i,
	input  logic [`HUB_LEVEL_W-1:0] fifo_level_i,
	input  logic                    dma_done_i,
	output logic                    run_o,
	output logic                    start_o,
	output logic                    capture_o,
	output dma_pkg::mem_addr_t      addr_first_o,
	output dma_pkg::mem_addr_t      addr_end_o
);
	localparam logic [`HUB_ADDR_W-1:0] LAST_REG = `HUB_REG_COUNT;

	logic              ack_q;
	logic              take;
	logic              addr_hit;
	logic              wr_en;
	io_pkg::status_t   wr_status;
	io_pkg::status_t   rd_status;
	io_pkg::reg_word_t drops;
	io_pkg::reg_word_t rd_word;
	io_pkg::reg_word_t rdata_q;

	assign take      = bus.stb && !ack_q; // First cycle of a request
	assign addr_hit  = (bus.addr != '0) && (bus.addr <= LAST_REG);
	assign wr_en     = take && bus.we && addr_hit;
	assign wr_status = io_pkg::status_t'(bus.wdata);

	// ##########################################################################
	// Read multiplexer

	always_comb begin
		rd_status         = '0;
		rd_status.run     = run_o;
		rd_status.capture = capture_o;
		rd_status.done    = dma_done_i;
		rd_status.full    = fifo_full_i;
		rd_status.empty   = fifo_empty_i;
		case (bus.addr)
			io_pkg::REG_STATUS:     rd_word = rd_status;
			io_pkg::REG_ADDR_FIRST: rd_word = io_pkg::reg_word_t'(addr_first_o);
			io_pkg::REG_ADDR_END:   rd_word = io_pkg::reg_word_t'(addr_end_o);
			io_pkg::REG_LEVEL:      rd_word = io_pkg::reg_word_t'(fifo_level_i);
			io_pkg::REG_DROPS:      rd_word = drops;
			default:                rd_word = '0;
		endcase
	end

	// ##########################################################################
	// Control registers and handshake

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q        <= 1'b0;
			start_o      <= 1'b0;
			run_o        <= 1'b0;
			capture_o    <= 1'b0;
			addr_first_o <= '0;
			addr_end_o   <= '0;
			drops        <= '0;
		end else begin
			ack_q   <= bus.stb; // Falls the cycle after stb falls
			start_o <= 1'b0;
			if (wr_en) begin
				case (bus.addr)
					io_pkg::REG_STATUS: begin
						run_o     <= wr_status.run;
						capture_o <= wr_status.capture;
						start_o   <= wr_status.run && !run_o;
					end
					io_pkg::REG_ADDR_FIRST: addr_first_o <= dma_pkg::mem_addr_t'(bus.wdata);
					io_pkg::REG_ADDR_END:   addr_end_o   <= dma_pkg::mem_addr_t'(bus.wdata);
					default: ; // Level and drops are read-only
				endcase
			end
			if (data_valid_i && capture_o && fifo_full_i)
				drops <= drops + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			rdata_q <= '0;
		else if (take)
			rdata_q <= rd_word;
	end

	assign bus.ack   = ack_q;
	assign bus.rdata = rdata_q;

endmodule

// ==== sync_fifo.sv ====
`timescale 1ns/1ps
`include "hub_consts.svh"

module sync_fifo #(
	parameter int DEPTH = `HUB_FIFO_DEPTH
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       push_i,
	input  dma_pkg::mem_word_t         din_i,
	input  logic                       pop_i,
	output dma_pkg::mem_word_t         dout_o,
	output logic                       full_o,
	output logic                       empty_o,
	output logic [$clog2(DEPTH+1)-1:0] level_o
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int LVL_W = $clog2(DEPTH + 1);

	dma_pkg::mem_word_t mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [LVL_W-1:0]   count;
	logic               do_push;
	logic               do_pop;

	// Pointer advance with wrap for any depth
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_next(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_next(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	assign dout_o  = mem[rd_ptr]; // Head word, no read latency
	assign full_o  = (count == LVL_W'(DEPTH));
	assign empty_o = (count == '0);
	assign level_o = count;

endmodule

// ==== hub_if.sv ====
`timescale 1ns/1ps
`include "hub_consts.svh"

// ##########################################################################
// Register access bus, strobe/acknowledge

interface io_bus_if;
	logic                   stb;
	logic                   we;
	logic [`HUB_ADDR_W-1:0] addr;
	io_pkg::reg_word_t      wdata;
	logic                   ack;
	io_pkg::reg_word_t      rdata;

	modport master (
		output stb,
		output we,
		output addr,
		output wdata,
		input  ack,
		input  rdata
	);

	modport slave (
		input  stb,
		input  we,
		input  addr,
		input  wdata,
		output ack,
		output rdata
	);
endinterface

// ##########################################################################
// Memory write bus, cyc is the grant from outside

interface mem_bus_if;
	logic                cyc;
	logic                stb;
	logic                we;
	dma_pkg::mem_addr_t  addr;
	dma_pkg::mem_word_t  data;
	logic                ack;

	modport master (
		input  cyc,
		output stb,
		output we,
		output addr,
		output data,
		input  ack
	);

	modport slave (
		input  cyc,
		input  stb,
		input  we,
		input  addr,
		input  data,
		output ack
	);
endinterface

// ==== dma_pkg.sv ====
`include "hub_consts.svh"

package dma_pkg;

	typedef logic [`HUB_ADDR_W-1:0] mem_addr_t;
	typedef logic [`HUB_DATA_W-1:0] mem_word_t;

	// DMA master FSM
	typedef enum logic [1:0] {
		DMA_IDLE,
		DMA_WRITE, // Words go out while the FIFO has data
		DMA_DONE   // Window finished, wait for run to drop
	} dma_state_e;

endpackage

// ==== io_pkg.sv ====
`include "hub_consts.svh"

package io_pkg;

	typedef logic [`HUB_DATA_W-1:0] reg_word_t;

	// I/O slave register map
	typedef enum logic [`HUB_ADDR_W-1:0] {
		REG_STATUS     = 1,
		REG_ADDR_FIRST = 2,
		REG_ADDR_END   = 3,
		REG_LEVEL      = 4,
		REG_DROPS      = 5
	} reg_addr_e;

	// Status word, MSB first
	typedef struct packed {
		logic [20:0] rsvd_hi;  // 31..11
		logic        empty;    // RO
		logic        full;     // RO
		logic        done;     // RO
		logic [4:0]  rsvd_mid; // 7..3
		logic        capture;  // RW
		logic        rsvd_lo;
		logic        run;      // RW
	} status_t;

endpackage

// ==== hub_consts.svh ====
`ifndef HUB_CONSTS_SVH
`define HUB_CONSTS_SVH

// Width of sample words, register words and memory words
`define HUB_DATA_W 32

// Width of I/O register addresses and memory addresses
`define HUB_ADDR_W 16

// Capture FIFO entries
`define HUB_FIFO_DEPTH 8

// Width of the FIFO occupancy count (0 to depth)
`define HUB_LEVEL_W $clog2(`HUB_FIFO_DEPTH + 1)

// Number of mapped I/O registers, starting at address 1
`define HUB_REG_COUNT 5

`endif
